//--- cregfile.sv
`timescale 1ns/1ns

module cregfile #(
  parameter int num_irq = 16
) (
  input  logic                   clk,
  input  logic                   reset,
  input  decode_pkg::cr_index_t  rd_index,
  output logic            [31:0] rd_data,
  input  logic                   cr_we,
  input  decode_pkg::reg_write_t wr,
  input  logic                   exc_in_wb,
  input  logic                   tlb_exc_in_wb,
  input  logic            [31:0] epc,
  input  logic            [31:0] efg,
  input  logic            [31:0] tlb_addr,
  input  logic     [num_irq-1:0] interrupts,
  input  logic                   interrupt_in_wb,
  input  logic                   rfe_in_wb,
  input  logic                   rfi_in_wb,
  output logic                   kmode,
  output logic            [31:0] cdv,
  output logic            [11:0] pid,
  output logic     [num_irq-1:0] irq_state
);
  import decode_pkg::*;

  logic               saved_kmode;
  logic [num_irq-1:0] imr;
  logic [num_irq-1:0] pending;
  logic [num_irq-1:0] pending_next;
  logic [31:0]        epc_q;
  logic [31:0]        efg_q;
  logic [31:0]        tlb_addr_q;
  cr_index_t          wr_index;
  logic               exc_entry;

  assign wr_index  = cr_index_t'(wr.target);  // target shared with wb_1
  assign exc_entry = exc_in_wb || interrupt_in_wb;
  assign irq_state = pending & imr;

  always_comb begin
    pending_next = pending | interrupts;
    if (cr_we && wr_index == cr_isr)
      pending_next = pending_next & ~wr.data[num_irq-1:0];  // write 1 to clear
    // entry retires the highest unmasked pending line
    if (interrupt_in_wb && irq_state != '0)
      pending_next[highest_bit(16'(irq_state))] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      kmode       <= 1'b1;
      saved_kmode <= 1'b0;
      pid         <= 12'd0;
      imr         <= '0;
      pending     <= '0;
    end else begin
      pending <= pending_next;
      if (cr_we && wr_index == cr_psr) begin
        kmode       <= wr.data[0];
        saved_kmode <= wr.data[1];
      end
      if (cr_we && wr_index == cr_pid) pid <= wr.data[11:0];
      if (cr_we && wr_index == cr_imr) imr <= wr.data[num_irq-1:0];
      if (exc_entry) begin
        saved_kmode <= kmode;
        kmode       <= 1'b1;
      end else if (rfe_in_wb || rfi_in_wb) begin
        kmode <= saved_kmode;
      end
    end
  end

  // saved exception state
  always_ff @(posedge clk) begin
    if (cr_we && wr_index == cr_epc) epc_q <= wr.data;
    if (cr_we && wr_index == cr_efg) efg_q <= wr.data;
    if (cr_we && wr_index == cr_tlb_addr) tlb_addr_q <= wr.data;
    if (cr_we && wr_index == cr_cdv) cdv <= wr.data;
    if (exc_entry) begin
      epc_q <= epc;
      efg_q <= efg;
      if (tlb_exc_in_wb) tlb_addr_q <= tlb_addr;
    end
  end

  always_comb begin
    case (rd_index)
      cr_psr:      rd_data = {30'd0, saved_kmode, kmode};
      cr_pid:      rd_data = {20'd0, pid};
      cr_imr:      rd_data = 32'(imr);
      cr_isr:      rd_data = 32'(pending);
      cr_epc:      rd_data = epc_q;
      cr_efg:      rd_data = efg_q;
      cr_tlb_addr: rd_data = tlb_addr_q;
      cr_cdv:      rd_data = cdv;
      default:     rd_data = 32'd0;
    endcase
  end

  // writeback retires one event per cycle
  a_entry_not_rfe: assert property (
    @(posedge clk) disable iff (reset) !(exc_entry && rfe_in_wb)
  ) else $error("exception entry and rfe in the same cycle");

endmodule

//--- decode_cases.txt
# i word pc flush bubble_in exc_in stalls | opcode alu imm tgt1 tgt2 s1 s2 ld/st/br/pi bubble exc
# w we1 t1 we2 t2 / c index data / e entry rfe kmode / q mask / h cycles
w 1 05 1 06
w 1 07 0 00
w 1 00 1 00
w 1 09 1 03
i 004A01C6 00000100 0 0 00 0 00 0e 00000000 01 00 05 06 0 0 00
i 088E31AB 00000104 0 0 00 0 01 03 0000AB00 02 00 07 00 0 0 00
i 08D29013 00000108 0 0 00 0 01 09 00000013 03 00 09 00 0 0 00
i 0906FFFC 0000010C 0 0 00 0 01 0f FFFFFFFC 04 00 03 00 0 0 00
i 11412345 00000110 0 0 00 0 02 12 048D1400 05 00 00 00 0 0 00
i 60FFFFF0 00000114 0 0 00 0 0c 1f FFFFFFF0 03 00 00 00 2 0 00
i 198BA804 00000118 0 0 00 0 03 1a FFFFE010 06 05 05 00 9 0 00
i 21D28001 0000011C 0 0 00 0 04 08 FFFF8001 00 00 09 07 4 0 00
i 2860ABCD 00000120 0 0 00 0 05 0a 0000ABCD 01 00 00 00 8 0 00
i 78000001 00000124 0 0 00 0 0f 00 00000000 00 00 00 00 0 0 01
i 78000002 00000128 0 0 00 0 0f 00 00000000 00 00 00 00 0 0 80
i A0000000 0000012C 0 0 00 0 14 00 00000000 00 00 00 00 0 0 80
i 004A01C6 00000130 0 0 42 0 00 0e 00000000 01 00 05 06 0 0 42
i 198BA804 00000134 1 0 00 0 03 1a FFFFE010 00 00 05 00 9 1 00
i 004A01C6 00000138 0 1 00 0 00 0e 00000000 00 00 05 06 0 1 00
i 088E31AB 0000013C 0 0 00 3 01 03 0000AB00 02 00 07 00 0 0 00
h 3
e 0 1 0
i F8881000 00000140 0 0 00 0 1f 01 00000000 00 00 04 02 0 0 81
e 1 0 1
i F8881000 00000144 0 0 00 0 1f 01 00000000 00 00 04 02 0 0 00
c 02 00000208
q 0208
i 004A01C6 00000148 0 0 00 0 00 0e 00000000 01 00 05 06 0 0 f9
c 03 00000200
i 004A01C6 0000014C 0 0 00 0 00 0e 00000000 01 00 05 06 0 0 f3
c 03 00000008
i 004A01C6 00000150 0 0 00 0 00 0e 00000000 01 00 05 06 0 0 00

//--- decode_pkg.sv
package decode_pkg;

  typedef enum logic [4:0] {
    op_alu_reg    = 5'd0,
    op_alu_imm    = 5'd1,
    op_lui        = 5'd2,
    op_mem_abs_w  = 5'd3,   // word forms
    op_mem_disp_w = 5'd4,
    op_mem_long_w = 5'd5,
    op_mem_abs_h  = 5'd6,   // half forms
    op_mem_disp_h = 5'd7,
    op_mem_long_h = 5'd8,
    op_mem_abs_b  = 5'd9,   // byte forms
    op_mem_disp_b = 5'd10,
    op_mem_long_b = 5'd11,
    op_br_imm     = 5'd12,
    op_br_abs     = 5'd13,
    op_br_rel     = 5'd14,
    op_syscall    = 5'd15,
    op_priv       = 5'd31
  } opcode_t;

  typedef enum logic [4:0] {
    priv_tlb_op = 5'd0,
    priv_cr_mov = 5'd1,
    priv_rfe    = 5'd2,
    priv_rfi    = 5'd3
  } priv_t;

  typedef enum logic [4:0] {
    cr_psr      = 5'd0,  // bit 0 kmode, bit 1 saved kmode
    cr_pid      = 5'd1,
    cr_imr      = 5'd2,
    cr_isr      = 5'd3,
    cr_epc      = 5'd4,
    cr_efg      = 5'd5,
    cr_tlb_addr = 5'd6,
    cr_cdv      = 5'd7
  } cr_index_t;

  parameter logic [7:0] exc_invalid_instr  = 8'h80;
  parameter logic [7:0] exc_priv_violation = 8'h81;
  parameter logic [7:0] irq_exc_base       = 8'hF0;  // irq i reports base + i

  typedef struct packed {
    logic        we;
    logic [4:0]  target;
    logic [31:0] data;
  } reg_write_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [4:0]  s_1;
    logic [4:0]  s_2;
    logic [4:0]  r_a;
    logic [4:0]  r_b;
    logic [4:0]  alu_op;
    logic [4:0]  branch_code;
    logic [31:0] imm;
    logic        is_load;
    logic        is_store;
    logic        is_branch;
    logic        is_absolute_mem;
    logic [1:0]  increment_type;  // 0 offset, 1 pre, 2 post
    priv_t       priv_type;
    logic [1:0]  crmov_mode_type;
    logic        tgts_cr;
    logic        tgts_ra;
    logic        tlb_we;
    logic        tlbc;
    logic [7:0]  exc;
  } dec_fields_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [4:0]  s_1;
    logic [4:0]  s_2;
    logic [4:0]  tgt_1;
    logic [4:0]  tgt_2;
    logic [4:0]  alu_op;
    logic [4:0]  branch_code;
    logic [31:0] imm;
    logic [31:0] pc;
    logic        bubble;
    logic        is_load;
    logic        is_store;
    logic        is_branch;
    logic        is_post_inc;
    logic        tgts_cr;
    priv_t       priv_type;
    logic [1:0]  crmov_mode_type;
    logic        tlb_we;
    logic        tlbc;
    logic [7:0]  exc;
  } dx_bundle_t;

  // index of the highest set bit, 0 when none
  function automatic logic [3:0] highest_bit(input logic [15:0] v);
    logic [3:0] idx;
    idx = 4'd0;
    for (int i = 0; i < 16; i++) begin
      if (v[i]) idx = i[3:0];
    end
    return idx;
  endfunction

endpackage

//--- decode_stage.sv
`timescale 1ns/1ns

module decode_stage #(
  parameter int num_irq = 16
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    flush,
  input  logic                    halt,
  input  logic                    stall,
  input  logic             [31:0] mem_out,
  input  logic                    bubble_in,
  input  logic             [31:0] pc_in,
  input  decode_pkg::reg_write_t  wb_1,
  input  decode_pkg::reg_write_t  wb_2,
  input  logic                    cr_we,
  input  logic              [7:0] exc_in,
  input  logic             [31:0] epc,
  input  logic             [31:0] efg,
  input  logic             [31:0] tlb_addr,
  input  logic                    exc_in_wb,
  input  logic                    tlb_exc_in_wb,
  input  logic      [num_irq-1:0] interrupts,
  input  logic                    interrupt_in_wb,
  input  logic                    rfe_in_wb,
  input  logic                    rfi_in_wb,
  output decode_pkg::dx_bundle_t  dx,
  output logic             [31:0] d_1,
  output logic             [31:0] d_2,
  output logic             [31:0] cr_d,
  output logic                    kmode,
  output logic             [11:0] pid,
  output logic             [31:0] cdv
);
  import decode_pkg::*;

  logic [31:0]        instr_buf;
  logic               was_stall;
  logic [31:0]        instr;
  dec_fields_t        fields;
  logic [num_irq-1:0] irq_state;
  logic               no_tgt;
  dx_bundle_t         dx_next;

  // memory may have moved on during a stall, replay the held word once
  assign instr = was_stall ? instr_buf : mem_out;

  instr_decoder u_decoder (
    .instr  (instr),
    .kmode  (kmode),
    .fields (fields)
  );

  regfile u_regfile (
    .clk   (clk),
    .reset (reset),
    .s_1   (fields.s_1),
    .s_2   (fields.s_2),
    .d_1   (d_1),
    .d_2   (d_2),
    .wb_1  (wb_1),
    .wb_2  (wb_2)
  );

  cregfile #(.num_irq(num_irq)) u_cregfile (
    .clk             (clk),
    .reset           (reset),
    .rd_index        (cr_index_t'(fields.r_b)),
    .rd_data         (cr_d),
    .cr_we           (cr_we),
    .wr              (wb_1),
    .exc_in_wb       (exc_in_wb),
    .tlb_exc_in_wb   (tlb_exc_in_wb),
    .epc             (epc),
    .efg             (efg),
    .tlb_addr        (tlb_addr),
    .interrupts      (interrupts),
    .interrupt_in_wb (interrupt_in_wb),
    .rfe_in_wb       (rfe_in_wb),
    .rfi_in_wb       (rfi_in_wb),
    .kmode           (kmode),
    .cdv             (cdv),
    .pid             (pid),
    .irq_state       (irq_state)
  );

  assign no_tgt = flush || bubble_in;

  always_comb begin
    dx_next                 = '0;
    dx_next.opcode          = fields.opcode;
    dx_next.s_1             = fields.s_1;
    dx_next.s_2             = fields.s_2;
    dx_next.tgt_1 = (no_tgt || fields.is_store || fields.tgts_ra) ? 5'd0 : fields.r_a;
    dx_next.tgt_2 = (no_tgt || !fields.is_absolute_mem || fields.increment_type == 2'd0)
                    ? 5'd0 : fields.r_b;  // base update for pre/post increment
    dx_next.alu_op          = fields.alu_op;
    dx_next.branch_code     = fields.branch_code;
    dx_next.imm             = fields.imm;
    dx_next.pc              = pc_in;
    dx_next.bubble          = flush || bubble_in;
    dx_next.is_load         = fields.is_load;
    dx_next.is_store        = fields.is_store;
    dx_next.is_branch       = fields.is_branch;
    dx_next.is_post_inc     = fields.is_absolute_mem && fields.increment_type == 2'd2;
    dx_next.tgts_cr         = fields.tgts_cr;
    dx_next.priv_type       = fields.priv_type;
    dx_next.crmov_mode_type = fields.crmov_mode_type;
    dx_next.tlb_we          = fields.tlb_we;
    dx_next.tlbc            = fields.tlbc;
    // interrupts first, then upstream exceptions, then the decoder
    if (irq_state != '0)
      dx_next.exc = irq_exc_base + 8'(highest_bit(16'(irq_state)));
    else if (exc_in != 8'd0)
      dx_next.exc = exc_in;
    else
      dx_next.exc = fields.exc;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dx.bubble <= 1'b1;
      dx.tgt_1  <= 5'd0;
      dx.tgt_2  <= 5'd0;
      dx.exc    <= 8'd0;
      dx.tlb_we <= 1'b0;
      dx.tlbc   <= 1'b0;
    end else if (!halt && !stall) begin
      dx <= dx_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) was_stall <= 1'b0;
    else if (!halt) was_stall <= stall;
  end

  // hold the first stalled word until the stall ends
  always_ff @(posedge clk) begin
    if (!halt && !(stall && was_stall)) instr_buf <= mem_out;
  end

  a_tlb_one_op: assert property (
    @(posedge clk) disable iff (reset) !(dx.tlb_we && dx.tlbc)
  ) else $error("dx carries both tlb_we and tlbc");

endmodule

//--- decode_top.sv
`timescale 1ns/1ns

module decode_top #(
  parameter int num_irq = 16
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    flush,
  input  logic                    halt,
  input  logic                    stall,
  input  logic             [31:0] mem_out,
  input  logic                    bubble_in,
  input  logic             [31:0] pc_in,
  input  decode_pkg::reg_write_t  wb_1,
  input  decode_pkg::reg_write_t  wb_2,
  input  logic                    cr_we,
  input  logic              [7:0] exc_in,
  input  logic             [31:0] epc,
  input  logic             [31:0] efg,
  input  logic             [31:0] tlb_addr,
  input  logic                    exc_in_wb,
  input  logic                    tlb_exc_in_wb,
  input  logic      [num_irq-1:0] interrupts,
  input  logic                    interrupt_in_wb,
  input  logic                    rfe_in_wb,
  input  logic                    rfi_in_wb,
  output decode_pkg::dx_bundle_t  dx,
  output logic             [31:0] d_1,
  output logic             [31:0] d_2,
  output logic             [31:0] cr_d,
  output logic                    kmode,
  output logic             [11:0] pid,
  output logic             [31:0] cdv
);

  decode_stage #(.num_irq(num_irq)) u_stage (
    .clk             (clk),
    .reset           (reset),
    .flush           (flush),
    .halt            (halt),
    .stall           (stall),
    .mem_out         (mem_out),
    .bubble_in       (bubble_in),
    .pc_in           (pc_in),
    .wb_1            (wb_1),
    .wb_2            (wb_2),
    .cr_we           (cr_we),
    .exc_in          (exc_in),
    .epc             (epc),
    .efg             (efg),
    .tlb_addr        (tlb_addr),
    .exc_in_wb       (exc_in_wb),
    .tlb_exc_in_wb   (tlb_exc_in_wb),
    .interrupts      (interrupts),
    .interrupt_in_wb (interrupt_in_wb),
    .rfe_in_wb       (rfe_in_wb),
    .rfi_in_wb       (rfi_in_wb),
    .dx              (dx),
    .d_1             (d_1),
    .d_2             (d_2),
    .cr_d            (cr_d),
    .kmode           (kmode),
    .pid             (pid),
    .cdv             (cdv)
  );

endmodule

//--- instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
  input  logic                    [31:0] instr,
  input  logic                           kmode,
  output decode_pkg::dec_fields_t        fields
);
  import decode_pkg::*;

  logic [4:0] op_bits;
  opcode_t    opcode;
  logic       is_br_reg;
  logic [4:0] r_a;
  logic [4:0] r_b;
  logic [4:0] r_c;
  logic [4:0] alu_op;
  logic       is_bitwise;
  logic       is_shift;
  logic       is_arith;
  logic       is_alu;
  logic       is_mem;
  logic       is_branch;
  logic       is_abs;
  logic       is_disp;
  logic       is_long;
  logic       is_syscall;
  logic       is_priv;
  logic       load_bit;
  logic [4:0] priv_bits;
  logic [1:0] crmov;
  logic       invalid;
  logic [7:0] exc_code;
  logic [31:0] imm;

  assign op_bits = instr[31:27];
  assign opcode  = opcode_t'(op_bits);

  // register branches keep r_a and r_b in the low fields
  assign is_br_reg = (opcode == op_br_abs) || (opcode == op_br_rel);
  assign r_a       = is_br_reg ? instr[9:5] : instr[26:22];
  assign r_b       = is_br_reg ? instr[4:0] : instr[21:17];
  assign r_c       = instr[4:0];
  assign alu_op    = (opcode == op_alu_reg) ? instr[9:5] : instr[16:12];

  assign is_bitwise = alu_op <= 5'd6;
  assign is_shift   = alu_op inside {[5'd7:5'd13]};
  assign is_arith   = alu_op inside {[5'd14:5'd18]};

  assign is_alu     = (opcode == op_alu_reg) || (opcode == op_alu_imm);
  assign is_mem     = op_bits inside {[5'd3:5'd11]};
  assign is_branch  = op_bits inside {[5'd12:5'd14]};
  assign is_abs     = opcode inside {op_mem_abs_w, op_mem_abs_h, op_mem_abs_b};
  assign is_disp    = opcode inside {op_mem_disp_w, op_mem_disp_h, op_mem_disp_b};
  assign is_long    = opcode inside {op_mem_long_w, op_mem_long_h, op_mem_long_b};
  assign is_syscall = opcode == op_syscall;
  assign is_priv    = opcode == op_priv;

  assign load_bit  = is_long ? instr[21] : instr[16];  // long forms use bit 21
  assign priv_bits = instr[16:12];
  assign crmov     = instr[11:10];

  assign invalid = (op_bits inside {[5'd16:5'd30]})
                || (is_alu && alu_op > 5'd18)
                || (is_branch && instr[26:22] > 5'd18)
                || (is_syscall && instr[7:0] != 8'd1)
                || (is_priv && priv_bits > 5'd3);

  assign exc_code = invalid             ? exc_invalid_instr  :
                    (is_priv && !kmode) ? exc_priv_violation :
                    is_syscall          ? instr[7:0]         :
                                          8'd0;

  always_comb begin
    imm = 32'd0;
    if (opcode == op_alu_imm && is_bitwise)
      imm = {24'd0, instr[7:0]} << {instr[9:8], 3'b000};  // byte lane shift
    else if (opcode == op_alu_imm && is_shift)
      imm = {27'd0, instr[4:0]};
    else if (opcode == op_alu_imm && is_arith)
      imm = {{20{instr[11]}}, instr[11:0]};
    else if (opcode == op_lui)
      imm = {instr[21:0], 10'd0};
    else if (opcode == op_br_imm)
      imm = {{10{instr[21]}}, instr[21:0]};
    else if (is_abs)
      imm = {{20{instr[11]}}, instr[11:0]} << instr[13:12];
    else if (is_disp)
      imm = {{16{instr[15]}}, instr[15:0]};
    else if (is_long)
      imm = {{11{instr[20]}}, instr[20:0]};
  end

  always_comb begin
    fields                 = '0;
    fields.opcode          = opcode;
    fields.r_a             = r_a;
    fields.r_b             = r_b;
    fields.alu_op          = alu_op;
    fields.branch_code     = instr[26:22];
    fields.imm             = imm;
    fields.is_load         = is_mem && load_bit;
    fields.is_store        = is_mem && !load_bit;
    fields.is_branch       = is_branch;
    fields.is_absolute_mem = is_abs;
    fields.increment_type  = instr[15:14];
    fields.priv_type       = priv_t'(priv_bits);
    fields.crmov_mode_type = crmov;
    fields.tgts_cr  = is_priv && priv_bits == 5'd1 && (crmov == 2'd0 || crmov == 2'd2);
    fields.tgts_ra  = is_priv && ((priv_bits == 5'd0 && crmov == 2'd0) || priv_bits == 5'd1);
    fields.tlb_we   = is_priv && priv_bits == 5'd0 && crmov == 2'd1;
    fields.tlbc     = is_priv && priv_bits == 5'd0 && crmov == 2'd2;
    fields.exc      = exc_code;
    // forms that never read r_b
    if (opcode inside {op_lui, op_br_imm, op_syscall} || is_long || (is_alu && alu_op == 5'd6))
      fields.s_1 = 5'd0;
    else
      fields.s_1 = r_b;
    // stores and priv read r_a, only alu_reg reads r_c
    if ((is_mem && !load_bit) || is_priv)
      fields.s_2 = r_a;
    else if (opcode == op_alu_reg)
      fields.s_2 = r_c;
    else
      fields.s_2 = 5'd0;
  end

endmodule

//--- regfile.sv
`timescale 1ns/1ns

module regfile (
  input  logic                   clk,
  input  logic                   reset,
  input  logic            [4:0]  s_1,
  input  logic            [4:0]  s_2,
  output logic            [31:0] d_1,
  output logic            [31:0] d_2,
  input  decode_pkg::reg_write_t wb_1,
  input  decode_pkg::reg_write_t wb_2
);

  logic [31:0] regs [32];

  // register 0 is never written so it reads as zero
  assign d_1 = regs[s_1];
  assign d_2 = regs[s_2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else begin
      if (wb_1.we && wb_1.target != 5'd0) regs[wb_1.target] <= wb_1.data;
      if (wb_2.we && wb_2.target != 5'd0) regs[wb_2.target] <= wb_2.data;  // wb_2 wins
    end
  end

  // writeback never issues two writes to one live register
  a_no_dual_write: assert property (
    @(posedge clk) disable iff (reset)
    !(wb_1.we && wb_2.we && wb_1.target == wb_2.target && wb_1.target != 5'd0)
  ) else $error("wb_1 and wb_2 both write r%0d", wb_1.target);

endmodule

//--- sources.f
decode_pkg.sv
instr_decoder.sv
regfile.sv
cregfile.sv
decode_stage.sv
decode_top.sv
tb_decode.sv

//--- tb_decode.sv
`timescale 1ns/1ns

module tb_decode;
  import decode_pkg::*;

  logic        clk;
  logic        reset;
  logic        flush;
  logic        halt;
  logic        stall;
  logic [31:0] mem_out;
  logic        bubble_in;
  logic [31:0] pc_in;
  reg_write_t  wb_1;
  reg_write_t  wb_2;
  logic        cr_we;
  logic [7:0]  exc_in;
  logic [31:0] epc;
  logic [31:0] efg;
  logic [31:0] tlb_addr;
  logic        exc_in_wb;
  logic        tlb_exc_in_wb;
  logic [15:0] interrupts;
  logic        interrupt_in_wb;
  logic        rfe_in_wb;
  logic        rfi_in_wb;
  dx_bundle_t  dx;
  logic [31:0] d_1;
  logic [31:0] d_2;
  logic [31:0] cr_d;
  logic        kmode;
  logic [11:0] pid;
  logic [31:0] cdv;

  logic [31:0] model_regs [32];  // expected general registers
  logic [15:0] pending_model;    // expected isr bits
  int          seed = 32'h34643503;
  int          fd;
  int          ncases;
  int          cycles;
  int          limit;

  decode_top #(.num_irq(16)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) abort_run("timeout, the DUT stopped making progress");
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp, got);
    $display("[FAIL] %0t ns: %s expected %h got %h", $time, name, exp, got);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, got);
    if (exp !== got) report_mismatch(name, exp, got);
  endtask

  task automatic check_exc(input logic [7:0] exp, got);
    if (exp !== got) report_mismatch("dx.exc", 32'(exp), 32'(got));
  endtask

  task automatic check_bit(input string name, input logic exp, got);
    if (exp !== got) report_mismatch(name, 32'(exp), 32'(got));
  endtask

  task automatic check_bundle(input dx_bundle_t exp, got);
    if (exp.opcode !== got.opcode) report_mismatch("dx.opcode", 32'(exp.opcode), 32'(got.opcode));
    if (exp.alu_op !== got.alu_op) report_mismatch("dx.alu_op", 32'(exp.alu_op), 32'(got.alu_op));
    check_word("dx.imm", exp.imm, got.imm);
    check_word("dx.pc", exp.pc, got.pc);
    if (exp.tgt_1 !== got.tgt_1) report_mismatch("dx.tgt_1", 32'(exp.tgt_1), 32'(got.tgt_1));
    if (exp.tgt_2 !== got.tgt_2) report_mismatch("dx.tgt_2", 32'(exp.tgt_2), 32'(got.tgt_2));
    if (exp.s_1 !== got.s_1) report_mismatch("dx.s_1", 32'(exp.s_1), 32'(got.s_1));
    if (exp.s_2 !== got.s_2) report_mismatch("dx.s_2", 32'(exp.s_2), 32'(got.s_2));
    check_bit("dx.is_load", exp.is_load, got.is_load);
    check_bit("dx.is_store", exp.is_store, got.is_store);
    check_bit("dx.is_branch", exp.is_branch, got.is_branch);
    check_bit("dx.is_post_inc", exp.is_post_inc, got.is_post_inc);
    check_bit("dx.bubble", exp.bubble, got.bubble);
  endtask

  // one instruction, optionally held by a stall of n cycles first
  task automatic run_instr();
    logic [31:0] word, pc, imm;
    logic [7:0]  fl, bub, xin, opc, alu, t1, t2, s1, s2, flags, ebub, exc;
    int          n, r;
    dx_bundle_t  exp, held;
    r = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", word, pc, fl, bub,
                xin, n, opc, alu, imm, t1, t2, s1, s2, flags, ebub, exc);
    if (r != 16) abort_run("malformed instruction line in the case file");
    exp             = '0;
    exp.opcode      = opcode_t'(opc[4:0]);
    exp.alu_op      = alu[4:0];
    exp.imm         = imm;
    exp.pc          = pc;
    exp.tgt_1       = t1[4:0];
    exp.tgt_2       = t2[4:0];
    exp.s_1         = s1[4:0];
    exp.s_2         = s2[4:0];
    exp.is_load     = flags[3];
    exp.is_store    = flags[2];
    exp.is_branch   = flags[1];
    exp.is_post_inc = flags[0];
    exp.bubble      = ebub[0];
    @(posedge clk);
    mem_out   <= word;
    pc_in     <= pc;
    flush     <= fl[0];
    bubble_in <= bub[0];
    exc_in    <= xin;
    stall     <= (n > 0);
    @(negedge clk);
    held = dx;
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      mem_out <= $random(seed);  // memory moves on while stalled
      if (k == n - 1) stall <= 1'b0;
      @(negedge clk);
      check_bundle(held, dx);
      check_exc(held.exc, dx.exc);
    end
    check_word("d_1", model_regs[s1[4:0]], d_1);
    check_word("d_2", model_regs[s2[4:0]], d_2);
    @(posedge clk);
    flush     <= 1'b0;
    bubble_in <= 1'b0;
    exc_in    <= 8'd0;
    @(negedge clk);
    check_bundle(exp, dx);
    check_exc(exc, dx.exc);
  endtask

  task automatic apply_writes();
    logic [7:0]  we1, t1, we2, t2;
    logic [31:0] v1, v2;
    int          r;
    r = $fscanf(fd, "%h %h %h %h", we1, t1, we2, t2);
    if (r != 4) abort_run("malformed register write line in the case file");
    v1 = $random(seed);
    v2 = $random(seed);
    @(posedge clk);
    wb_1 <= '{we: we1[0], target: t1[4:0], data: v1};
    wb_2 <= '{we: we2[0], target: t2[4:0], data: v2};
    if (we1[0] && t1[4:0] != 5'd0) model_regs[t1[4:0]] = v1;
    if (we2[0] && t2[4:0] != 5'd0) model_regs[t2[4:0]] = v2;  // second port wins
    @(posedge clk);
    wb_1 <= '0;
    wb_2 <= '0;
  endtask

  // write one control register, then read it back through the r_b port
  task automatic write_cr(input cr_index_t idx, input logic [31:0] val);
    logic [31:0] exp;
    case (idx)
      cr_psr: exp = {30'd0, val[1:0]};
      cr_pid: exp = {20'd0, val[11:0]};
      cr_imr: exp = {16'd0, val[15:0]};
      cr_isr: begin
        pending_model = pending_model & ~val[15:0];  // write 1 to clear
        exp           = {16'd0, pending_model};
      end
      default: exp = val;
    endcase
    @(posedge clk);
    cr_we <= 1'b1;
    wb_1  <= '{we: 1'b0, target: idx, data: val};
    @(posedge clk);
    cr_we   <= 1'b0;
    wb_1    <= '0;
    mem_out <= {10'd0, idx, 17'd0};  // alu_reg word with r_b = idx
    @(negedge clk);
    check_word("cr_d", exp, cr_d);
    if (idx == cr_pid) check_word("pid", exp, 32'(pid));
    if (idx == cr_cdv) check_word("cdv", exp, cdv);
  endtask

  task automatic apply_cr_write();
    logic [7:0]  idx;
    logic [31:0] val;
    int          r;
    r = $fscanf(fd, "%h %h", idx, val);
    if (r != 2) abort_run("malformed control register line in the case file");
    write_cr(cr_index_t'(idx[4:0]), val);
  endtask

  task automatic apply_event();
    logic [7:0] ent, rfe, exp_k;
    int         r;
    r = $fscanf(fd, "%h %h %h", ent, rfe, exp_k);
    if (r != 3) abort_run("malformed event line in the case file");
    @(posedge clk);
    exc_in_wb <= ent[0];
    rfe_in_wb <= rfe[0];
    @(posedge clk);
    exc_in_wb <= 1'b0;
    rfe_in_wb <= 1'b0;
    @(negedge clk);
    check_bit("kmode", exp_k[0], kmode);
  endtask

  task automatic pulse_interrupts();
    logic [15:0] mask;
    int          r;
    r = $fscanf(fd, "%h", mask);
    if (r != 1) abort_run("malformed interrupt line in the case file");
    pending_model = pending_model | mask;
    @(posedge clk);
    interrupts <= mask;
    @(posedge clk);
    interrupts <= '0;
  endtask

  task automatic hold_halt();
    dx_bundle_t held;
    int         n, r;
    r = $fscanf(fd, "%h", n);
    if (r != 1) abort_run("malformed halt line in the case file");
    @(posedge clk);
    halt    <= 1'b1;
    mem_out <= $random(seed);
    @(negedge clk);
    held = dx;
    repeat (n) begin
      @(posedge clk);
      mem_out <= $random(seed);
      @(negedge clk);
      check_bundle(held, dx);
      check_exc(held.exc, dx.exc);
    end
    @(posedge clk);
    halt <= 1'b0;
  endtask

  initial begin
    string       kind;
    string       line;
    int          r;
    logic [31:0] cr_val;
    reset <= 1'b1;
    {flush, halt, stall, bubble_in, cr_we} <= '0;
    {mem_out, pc_in, epc, efg, tlb_addr} <= '0;
    {wb_1, wb_2, exc_in, interrupts} <= '0;
    {exc_in_wb, tlb_exc_in_wb, interrupt_in_wb, rfe_in_wb, rfi_in_wb} <= '0;
    cycles        = 0;
    limit         = 0;
    ncases        = 0;
    pending_model = '0;
    for (int i = 0; i < 32; i++) model_regs[i] = 32'd0;
    // count cases to size the timeout
    fd = $fopen("decode_cases.txt", "r");
    if (fd == 0) abort_run("cannot open decode_cases.txt");
    while (!$feof(fd)) begin
      if ($fgets(line, fd) && line.len() > 1 && line.getc(0) != 8'h23) ncases++;
    end
    $fclose(fd);
    limit = ncases * 20 + 100;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_bit("dx.bubble", 1'b1, dx.bubble);
    check_word("dx.tgt_1", 32'd0, 32'(dx.tgt_1));
    check_word("dx.tgt_2", 32'd0, 32'(dx.tgt_2));
    check_exc(8'd0, dx.exc);
    check_bit("dx.tlb_we", 1'b0, dx.tlb_we);
    check_bit("dx.tlbc", 1'b0, dx.tlbc);
    check_bit("kmode", 1'b1, kmode);
    check_word("pid", 32'd0, 32'(pid));
    // cdv and pid only change by a control register write
    cr_val = $random(seed);
    write_cr(cr_cdv, cr_val);
    cr_val = $random(seed);
    write_cr(cr_pid, cr_val);
    fd = $fopen("decode_cases.txt", "r");
    while (!$feof(fd)) begin
      r = $fscanf(fd, "%s", kind);
      if (r != 1) break;
      case (kind)
        "#": r = $fgets(line, fd);  // comment line
        "i": run_instr();
        "w": apply_writes();
        "c": apply_cr_write();
        "e": apply_event();
        "q": pulse_interrupts();
        "h": hold_halt();
        default: abort_run($sformatf("unknown case kind %s", kind));
      endcase
    end
    $fclose(fd);
    $display("Simulation PASSED");
    $finish;
  end

endmodule
